//--- sdram_pkg.sv
package sdram_pkg;

	// geometry of the modelled part
	localparam int bank_bits = 2;
	localparam int row_bits = 12;
	localparam int col_bits = 8;
	localparam int beat_bits = 16;
	localparam int word_bits = 32;

	// timing in sdram_clk cycles, kept short for simulation
	localparam int t_init_wait = 20;
	localparam int t_cke = 5;
	localparam int t_rp = 2;
	localparam int t_rfc = 6;
	localparam int t_mrd = 2;
	localparam int t_rcd = 2;
	localparam int t_wr = 2;
	localparam int cas_latency = 2;

	// burst length 2, sequential, cas latency 2, burst writes
	localparam logic [row_bits-1:0] mode_word = 12'h021;

	// encoded as {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		cmd_mode_register = 3'b000,
		cmd_auto_refresh  = 3'b001,
		cmd_precharge     = 3'b010,
		cmd_active        = 3'b011,
		cmd_write         = 3'b100,
		cmd_read          = 3'b101,
		cmd_nop           = 3'b111
	} sdram_cmd_e;

	// one cycle on the command bus
	typedef struct packed {
		sdram_cmd_e cmd;
		logic [bank_bits-1:0] bank;
		logic [row_bits-1:0] addr;
		logic [1:0] dqm;
	} sdram_bus_t;

	// write FIFO entry, a set mask bit drops that byte
	typedef struct packed {
		logic [word_bits-1:0] data;
		logic [3:0] mask;
	} wr_word_t;

	// host word address
	typedef struct packed {
		logic [bank_bits-1:0] bank;
		logic [row_bits-1:0] row;
		logic [col_bits-1:0] col;
	} host_addr_t;

	localparam sdram_bus_t bus_nop = '{
		cmd: cmd_nop,
		bank: '0,
		addr: '0,
		dqm: '0
	};

	// column part of a READ or WRITE
	// A10 stays low so there is no auto precharge, the LSB picks the first beat
	function automatic logic [row_bits-1:0] col_addr(host_addr_t a);
		return {3'b000, a.col, 1'b0};
	endfunction

endpackage

//--- sdram_fifo.sv
module sdram_fifo #(
	parameter int width = 32,
	parameter int fifo_depth_log2 = 3
) (
	input  logic sdram_clk,
	input  logic sdram_reset,
	input  logic push,
	input  logic [width-1:0] push_data,
	input  logic pop,
	output logic [width-1:0] pop_data,
	output logic full,
	output logic empty
);
	localparam int depth = 1 << fifo_depth_log2;

	logic [width-1:0] mem [depth];
	logic [fifo_depth_log2-1:0] wr_ptr;
	logic [fifo_depth_log2-1:0] rd_ptr;
	logic [fifo_depth_log2:0] count;

	always_ff @(posedge sdram_clk) begin
		if (sdram_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge sdram_clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// head entry falls through
	assign pop_data = mem[rd_ptr];
	assign full = count == (fifo_depth_log2 + 1)'(depth);
	assign empty = count == '0;

	a_no_overflow: assert property (@(posedge sdram_clk) disable iff (sdram_reset)
		push |-> !full);
	a_no_underflow: assert property (@(posedge sdram_clk) disable iff (sdram_reset)
		pop |-> !empty);

endmodule

//--- sdram_write.sv
module sdram_write (
	input  logic sdram_clk,
	input  logic sdram_reset,
	input  logic start,
	input  sdram_pkg::host_addr_t address,
	input  sdram_pkg::wr_word_t word,
	output logic word_pop,
	output logic busy,
	output sdram_pkg::sdram_bus_t bus,
	output logic [sdram_pkg::beat_bits-1:0] data_out,
	output logic data_drive
);
	typedef enum logic [2:0] {
		wr_idle,
		wr_activate,
		wr_rcd,
		wr_write,
		wr_beat2,
		wr_recover,
		wr_precharge,
		wr_rp
	} wr_state_e;

	wr_state_e state;
	logic [3:0] delay;
	logic [sdram_pkg::beat_bits-1:0] data_hi;
	logic [1:0] mask_hi;

	always_ff @(posedge sdram_clk) begin
		if (sdram_reset) begin
			state <= wr_idle;
			delay <= '0;
		end else begin
			case (state)
				wr_idle: begin
					if (start) begin
						state <= wr_activate;
					end
				end
				wr_activate: begin
					delay <= 4'(sdram_pkg::t_rcd - 1);
					state <= wr_rcd;
				end
				wr_rcd: begin
					if (delay == 0) begin
						state <= wr_write;
					end else begin
						delay <= delay - 4'd1;
					end
				end
				wr_write: state <= wr_beat2;
				wr_beat2: begin
					delay <= 4'(sdram_pkg::t_wr - 1);
					state <= wr_recover;
				end
				wr_recover: begin
					if (delay == 0) begin
						state <= wr_precharge;
					end else begin
						delay <= delay - 4'd1;
					end
				end
				// precharge cycle counts as the first of t_rp
				wr_precharge: begin
					delay <= 4'(sdram_pkg::t_rp - 2);
					state <= wr_rp;
				end
				wr_rp: begin
					if (delay == 0) begin
						state <= wr_idle;
					end else begin
						delay <= delay - 4'd1;
					end
				end
				default: state <= wr_idle;
			endcase
		end
	end

	// FIFO head moves on at the WRITE, keep the upper half for beat two
	always_ff @(posedge sdram_clk) begin
		if (state == wr_write) begin
			data_hi <= word.data[31:16];
			mask_hi <= word.mask[3:2];
		end
	end

	assign busy = state != wr_idle;
	assign word_pop = state == wr_write;
	assign data_drive = (state == wr_write) || (state == wr_beat2);
	assign data_out = (state == wr_beat2) ? data_hi : word.data[15:0];

	always_comb begin
		bus = sdram_pkg::bus_nop;
		case (state)
			wr_activate: begin
				bus.cmd = sdram_pkg::cmd_active;
				bus.bank = address.bank;
				bus.addr = address.row;
			end
			wr_write: begin
				bus.cmd = sdram_pkg::cmd_write;
				bus.bank = address.bank;
				bus.addr = sdram_pkg::col_addr(address);
				bus.dqm = word.mask[1:0];
			end
			wr_beat2: bus.dqm = mask_hi;
			wr_precharge: begin
				bus.cmd = sdram_pkg::cmd_precharge;
				bus.bank = address.bank;
			end
			default: ;
		endcase
	end

	a_start_idle: assert property (@(posedge sdram_clk) disable iff (sdram_reset)
		start |-> !busy);

endmodule

//--- sdram_read.sv
module sdram_read (
	input  logic sdram_clk,
	input  logic sdram_reset,
	input  logic start,
	input  sdram_pkg::host_addr_t address,
	input  logic [sdram_pkg::beat_bits-1:0] data_in,
	output logic busy,
	output sdram_pkg::sdram_bus_t bus,
	output logic word_push,
	output logic [sdram_pkg::word_bits-1:0] word
);
	typedef enum logic [3:0] {
		rd_idle,
		rd_activate,
		rd_rcd,
		rd_read,
		rd_cas,
		rd_low,
		rd_high,
		rd_precharge,
		rd_rp
	} rd_state_e;

	rd_state_e state;
	logic [3:0] delay;

	always_ff @(posedge sdram_clk) begin
		if (sdram_reset) begin
			state <= rd_idle;
			delay <= '0;
		end else begin
			case (state)
				rd_idle: begin
					if (start) begin
						state <= rd_activate;
					end
				end
				rd_activate: begin
					delay <= 4'(sdram_pkg::t_rcd - 1);
					state <= rd_rcd;
				end
				rd_rcd: begin
					if (delay == 0) begin
						state <= rd_read;
					end else begin
						delay <= delay - 4'd1;
					end
				end
				// READ cycle is the first of the cas latency
				rd_read: begin
					delay <= 4'(sdram_pkg::cas_latency - 2);
					state <= rd_cas;
				end
				rd_cas: begin
					if (delay == 0) begin
						state <= rd_low;
					end else begin
						delay <= delay - 4'd1;
					end
				end
				rd_low: state <= rd_high;
				rd_high: state <= rd_precharge;
				rd_precharge: begin
					delay <= 4'(sdram_pkg::t_rp - 2);
					state <= rd_rp;
				end
				rd_rp: begin
					if (delay == 0) begin
						state <= rd_idle;
					end else begin
						delay <= delay - 4'd1;
					end
				end
				default: state <= rd_idle;
			endcase
		end
	end

	// beats land low half first
	always_ff @(posedge sdram_clk) begin
		if (state == rd_low) begin
			word[15:0] <= data_in;
		end
		if (state == rd_high) begin
			word[31:16] <= data_in;
		end
	end

	assign busy = state != rd_idle;
	// assembled word goes out alongside the precharge
	assign word_push = state == rd_precharge;

	always_comb begin
		bus = sdram_pkg::bus_nop;
		case (state)
			rd_activate: begin
				bus.cmd = sdram_pkg::cmd_active;
				bus.bank = address.bank;
				bus.addr = address.row;
			end
			rd_read: begin
				bus.cmd = sdram_pkg::cmd_read;
				bus.bank = address.bank;
				bus.addr = sdram_pkg::col_addr(address);
			end
			rd_precharge: begin
				bus.cmd = sdram_pkg::cmd_precharge;
				bus.bank = address.bank;
			end
			default: ;
		endcase
	end

	// every accepted read hands back exactly one word, at a fixed distance
	a_one_word: assert property (@(posedge sdram_clk) disable iff (sdram_reset)
		start |-> ##(sdram_pkg::t_rcd + sdram_pkg::cas_latency + 4) word_push);

endmodule

//--- sdram.sv
module sdram #(
	parameter int refresh_interval = 200,
	parameter int fifo_depth_log2 = 3
) (
	input  logic sdram_clk,
	input  logic sdram_reset,
	input  logic wr_fifo_wr,
	input  logic [31:0] wr_fifo_data,
	input  logic [3:0] wr_fifo_mask,
	output logic wr_fifo_full,
	input  logic rd_fifo_rd,
	output logic [31:0] rd_fifo_data,
	output logic rd_fifo_empty,
	input  logic write_en,
	input  logic read_en,
	input  sdram_pkg::host_addr_t address,
	output logic sdram_ready,
	output logic cke,
	output logic cs_n,
	output logic ras_n,
	output logic cas_n,
	output logic we_n,
	output logic [11:0] addr,
	output logic [1:0] bank,
	output logic [1:0] data_mask,
	inout  wire  [15:0] data
);
	localparam int refresh_w = $clog2(refresh_interval);

	typedef enum logic [2:0] {
		st_reset_wait,
		st_cke_high,
		st_precharge,
		st_refresh_1,
		st_refresh_2,
		st_mode,
		st_ready
	} init_state_e;

	typedef enum logic [1:0] {
		own_ctrl,
		own_write,
		own_read
	} owner_e;

	init_state_e init_state;
	owner_e owner;
	logic [7:0] init_delay;
	logic [refresh_w-1:0] refresh_count;
	logic refresh_pending;
	logic refresh_go;
	logic start_wr;
	logic start_rd;
	logic accept_wr;
	logic accept_rd;
	sdram_pkg::host_addr_t addr_r;
	sdram_pkg::sdram_bus_t ctrl_bus;
	sdram_pkg::sdram_bus_t wr_bus;
	sdram_pkg::sdram_bus_t rd_bus;
	sdram_pkg::sdram_bus_t pin_bus;
	sdram_pkg::wr_word_t wr_push_word;
	sdram_pkg::wr_word_t wr_head;
	logic wr_fifo_empty;
	logic wr_pop;
	logic wr_busy;
	logic wr_drive;
	logic [15:0] wr_data_out;
	logic rd_busy;
	logic rd_push;
	logic [31:0] rd_word;
	logic rd_fifo_full;

	assign sdram_ready = (init_state == st_ready) && (init_delay == 0) && !refresh_pending
		&& !start_wr && !start_rd && !wr_busy && !rd_busy && !rd_fifo_full;
	// write wins when both strobes arrive together
	assign accept_wr = write_en && sdram_ready;
	assign accept_rd = read_en && !write_en && sdram_ready;
	assign refresh_go = (init_state == st_ready) && (init_delay == 0) && refresh_pending
		&& !start_wr && !start_rd && !wr_busy && !rd_busy;

	always_ff @(posedge sdram_clk) begin
		if (sdram_reset) begin
			init_state <= st_reset_wait;
			init_delay <= 8'(sdram_pkg::t_init_wait - 1);
			cke <= 1'b0;
			cs_n <= 1'b1;
			ctrl_bus <= sdram_pkg::bus_nop;
			owner <= own_ctrl;
			start_wr <= 1'b0;
			start_rd <= 1'b0;
		end else begin
			ctrl_bus <= sdram_pkg::bus_nop;
			start_wr <= accept_wr;
			start_rd <= accept_rd;
			if (accept_wr) begin
				owner <= own_write;
			end else if (accept_rd) begin
				owner <= own_read;
			end else if (refresh_go) begin
				owner <= own_ctrl;
			end
			if (init_delay != 0) begin
				init_delay <= init_delay - 8'd1;
			end else begin
				case (init_state)
					st_reset_wait: init_state <= st_cke_high;
					st_cke_high: begin
						cke <= 1'b1;
						cs_n <= 1'b0;
						init_delay <= 8'(sdram_pkg::t_cke);
						init_state <= st_precharge;
					end
					st_precharge: begin
						// A10 high selects all banks
						ctrl_bus.cmd <= sdram_pkg::cmd_precharge;
						ctrl_bus.addr <= 12'h400;
						init_delay <= 8'(sdram_pkg::t_rp);
						init_state <= st_refresh_1;
					end
					st_refresh_1: begin
						ctrl_bus.cmd <= sdram_pkg::cmd_auto_refresh;
						init_delay <= 8'(sdram_pkg::t_rfc);
						init_state <= st_refresh_2;
					end
					st_refresh_2: begin
						ctrl_bus.cmd <= sdram_pkg::cmd_auto_refresh;
						init_delay <= 8'(sdram_pkg::t_rfc);
						init_state <= st_mode;
					end
					st_mode: begin
						ctrl_bus.cmd <= sdram_pkg::cmd_mode_register;
						ctrl_bus.addr <= sdram_pkg::mode_word;
						init_delay <= 8'(sdram_pkg::t_mrd);
						init_state <= st_ready;
					end
					st_ready: begin
						if (refresh_go) begin
							ctrl_bus.cmd <= sdram_pkg::cmd_auto_refresh;
							init_delay <= 8'(sdram_pkg::t_rfc);
						end
					end
					default: init_state <= st_reset_wait;
				endcase
			end
		end
	end

	// refresh timer, pending stays set until the refresh goes out
	always_ff @(posedge sdram_clk) begin
		if (sdram_reset) begin
			refresh_count <= refresh_w'(refresh_interval - 1);
			refresh_pending <= 1'b0;
		end else if (init_state == st_ready) begin
			if (refresh_count == 0) begin
				refresh_count <= refresh_w'(refresh_interval - 1);
				refresh_pending <= 1'b1;
			end else begin
				refresh_count <= refresh_count - 1'b1;
				if (refresh_go) begin
					refresh_pending <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge sdram_clk) begin
		if (accept_wr || accept_rd) begin
			addr_r <= address;
		end
	end

	always_comb begin
		case (owner)
			own_write: pin_bus = wr_bus;
			own_read: pin_bus = rd_bus;
			default: pin_bus = ctrl_bus;
		endcase
	end

	assign {ras_n, cas_n, we_n} = pin_bus.cmd;
	assign bank = pin_bus.bank;
	assign addr = pin_bus.addr;
	assign data_mask = pin_bus.dqm;
	assign data = wr_drive ? wr_data_out : 16'hzzzz;

	assign wr_push_word = '{data: wr_fifo_data, mask: wr_fifo_mask};

	sdram_fifo #(
		.width($bits(sdram_pkg::wr_word_t)),
		.fifo_depth_log2(fifo_depth_log2)
	) wr_fifo (
		.sdram_clk(sdram_clk),
		.sdram_reset(sdram_reset),
		.push(wr_fifo_wr),
		.push_data(wr_push_word),
		.pop(wr_pop),
		.pop_data(wr_head),
		.full(wr_fifo_full),
		.empty(wr_fifo_empty)
	);

	sdram_fifo #(
		.width(32),
		.fifo_depth_log2(fifo_depth_log2)
	) rd_fifo (
		.sdram_clk(sdram_clk),
		.sdram_reset(sdram_reset),
		.push(rd_push),
		.push_data(rd_word),
		.pop(rd_fifo_rd),
		.pop_data(rd_fifo_data),
		.full(rd_fifo_full),
		.empty(rd_fifo_empty)
	);

	sdram_write write_engine (
		.sdram_clk(sdram_clk),
		.sdram_reset(sdram_reset),
		.start(start_wr),
		.address(addr_r),
		.word(wr_head),
		.word_pop(wr_pop),
		.busy(wr_busy),
		.bus(wr_bus),
		.data_out(wr_data_out),
		.data_drive(wr_drive)
	);

	sdram_read read_engine (
		.sdram_clk(sdram_clk),
		.sdram_reset(sdram_reset),
		.start(start_rd),
		.address(addr_r),
		.data_in(data),
		.busy(rd_busy),
		.bus(rd_bus),
		.word_push(rd_push),
		.word(rd_word)
	);

	// engines only reach the pins after the mode register load
	a_no_early_active: assert property (@(posedge sdram_clk) disable iff (sdram_reset)
		pin_bus.cmd == sdram_pkg::cmd_active |-> init_state == st_ready);
	// host has to push the data before it strobes write_en
	a_write_has_word: assert property (@(posedge sdram_clk) disable iff (sdram_reset)
		accept_wr |-> !wr_fifo_empty);

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
	parameter int reset_cycles = 16
) (
	output logic sdram_clk,
	output logic sdram_reset
);
	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period
	initial begin
		sdram_clk = 1'b0;
		forever #50 sdram_clk = ~sdram_clk;
	end

	// release lands just after an edge, like the rest of the stimulus
	initial begin
		sdram_reset = 1'b1;
		repeat (reset_cycles) @(posedge sdram_clk);
		#1 sdram_reset = 1'b0;
	end

endmodule

//--- tb_sdram_model.sv
module tb_sdram_model #(
	parameter int refresh_interval = 200
) (
	input  logic sdram_clk,
	input  logic sdram_reset,
	input  logic cke,
	input  logic cs_n,
	input  logic ras_n,
	input  logic cas_n,
	input  logic we_n,
	input  logic [11:0] addr,
	input  logic [1:0] bank,
	input  logic [1:0] data_mask,
	inout  wire  [15:0] data,
	output logic protocol_fault,
	output int refresh_seen
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int write_len = 2 + sdram_pkg::t_rcd + 2 + sdram_pkg::t_wr + sdram_pkg::t_rp;
	localparam int read_len = 2 + sdram_pkg::t_rcd + sdram_pkg::cas_latency + 2
		+ sdram_pkg::t_rp;
	localparam int longest_access = (write_len > read_len) ? write_len : read_len;
	localparam int refresh_limit = refresh_interval + longest_access + sdram_pkg::t_rfc;
	localparam int cl = sdram_pkg::cas_latency;

	// storage keyed by {bank, row, beat column}
	logic [15:0] mem [logic [22:0]];
	logic [11:0] open_row [4];
	logic [3:0] row_open;
	int last_active [4];
	int last_precharge [4];
	int last_refresh;
	// start of the current refresh gap, the mode load opens the first one
	int refresh_mark;
	int cycle;
	int init_step;
	int rd_stage;
	logic [22:0] rd_key;
	logic wr_second;
	logic [22:0] wr_key;
	logic [15:0] dq_out;
	logic dq_oe;
	logic init_done;
	sdram_pkg::sdram_cmd_e cmd;

	assign data = dq_oe ? dq_out : 16'hzzzz;
	assign cmd = cs_n ? sdram_pkg::cmd_nop : sdram_pkg::sdram_cmd_e'({ras_n, cas_n, we_n});

	task automatic note_fault(string what);
		$display("SDRAM model: %s at cycle %0d", what, cycle);
		protocol_fault = 1'b1;
	endtask

	function automatic logic [15:0] read_beat(logic [22:0] key);
		return mem.exists(key) ? mem[key] : 16'h0000;
	endfunction

	// a set dqm bit keeps the stored byte
	task automatic store_beat(logic [22:0] key, logic [15:0] d, logic [1:0] m);
		logic [15:0] old;
		old = read_beat(key);
		mem[key] = {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
	endtask

	always @(posedge sdram_clk) begin
		if (sdram_reset) begin
			cycle = 0;
			init_step = 0;
			last_refresh = 0;
			refresh_mark = 0;
			refresh_seen = 0;
			protocol_fault = 1'b0;
			rd_stage = 0;
			wr_second = 1'b0;
			row_open = 4'b0000;
			dq_oe <= 1'b0;
			dq_out <= 16'h0000;
			for (int b = 0; b < 4; b++) begin
				last_active[b] = -1000;
				last_precharge[b] = -1000;
			end
		end else begin
			cycle = cycle + 1;
			init_done = init_step == 4;
			// read data comes back cas latency edges after the READ
			if (rd_stage != 0) begin
				if (rd_stage == cl - 1) begin
					dq_out <= read_beat(rd_key);
					dq_oe <= 1'b1;
				end else if (rd_stage == cl) begin
					dq_out <= read_beat(rd_key ^ 23'd1);
				end else if (rd_stage == cl + 1) begin
					dq_oe <= 1'b0;
				end
				rd_stage = (rd_stage == cl + 1) ? 0 : rd_stage + 1;
			end
			if (wr_second) begin
				store_beat(wr_key, data, data_mask);
				wr_second = 1'b0;
			end
			if (cmd != sdram_pkg::cmd_nop) begin
				assert (cke) else note_fault("command issued while cke was low");
				case (cmd)
					sdram_pkg::cmd_active: begin
						assert (init_done) else note_fault("ACTIVE before the init sequence ended");
						assert (cycle - last_refresh >= sdram_pkg::t_rfc)
							else note_fault("ACTIVE within tRFC of AUTO_REFRESH");
						assert (cycle - last_precharge[bank] >= sdram_pkg::t_rp)
							else note_fault("ACTIVE within tRP of PRECHARGE");
						assert (!row_open[bank]) else note_fault("ACTIVE to a bank with an open row");
						row_open[bank] = 1'b1;
						open_row[bank] = addr;
						last_active[bank] = cycle;
					end
					sdram_pkg::cmd_read, sdram_pkg::cmd_write: begin
						assert (row_open[bank] && cycle - last_active[bank] >= sdram_pkg::t_rcd)
							else note_fault("READ or WRITE without an open row or before tRCD");
						if (cmd == sdram_pkg::cmd_read) begin
							rd_key = {bank, open_row[bank], addr[8:0]};
							rd_stage = 1;
						end else begin
							store_beat({bank, open_row[bank], addr[8:0]}, data, data_mask);
							wr_key = {bank, open_row[bank], addr[8:0]} ^ 23'd1;
							wr_second = 1'b1;
						end
					end
					sdram_pkg::cmd_precharge: begin
						for (int b = 0; b < 4; b++) begin
							if (addr[10] || b == int'(bank)) begin
								row_open[b] = 1'b0;
								last_precharge[b] = cycle;
							end
						end
					end
					sdram_pkg::cmd_auto_refresh: begin
						assert (row_open == 4'b0000) else note_fault("AUTO_REFRESH with a row open");
						if (init_done) begin
							assert (cycle - refresh_mark <= refresh_limit)
								else note_fault("gap between AUTO_REFRESH commands too long");
							refresh_seen = refresh_seen + 1;
						end
						last_refresh = cycle;
						refresh_mark = cycle;
					end
					default: ;
				endcase
				// power-up order: precharge all, two refreshes, mode load
				case (init_step)
					0: begin
						assert (cmd == sdram_pkg::cmd_precharge && addr[10])
							else note_fault("first command was not precharge all");
						init_step = 1;
					end
					1, 2: begin
						assert (cmd == sdram_pkg::cmd_auto_refresh)
							else note_fault("expected AUTO_REFRESH during init");
						init_step = init_step + 1;
					end
					3: begin
						assert (cmd == sdram_pkg::cmd_mode_register && addr == sdram_pkg::mode_word)
							else note_fault("expected MODE_REGISTER with the mode word");
						init_step = 4;
						refresh_mark = cycle;
					end
					default: ;
				endcase
			end
			if (init_step == 4) begin
				assert (cycle - refresh_mark <= refresh_limit) else note_fault("AUTO_REFRESH overdue");
			end
		end
	end

endmodule

//--- tb_sdram.sv
module tb_sdram;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int refresh_interval = 200;
	localparam int init_limit = 200;
	localparam int ready_limit = 64;
	localparam int write_count = 12;
	localparam int mask_count = 10;
	localparam int burst_reads = 6;

	logic sdram_clk;
	logic sdram_reset;
	logic wr_fifo_wr;
	logic [31:0] wr_fifo_data;
	logic [3:0] wr_fifo_mask;
	logic wr_fifo_full;
	logic rd_fifo_rd;
	logic [31:0] rd_fifo_data;
	logic rd_fifo_empty;
	logic write_en;
	logic read_en;
	sdram_pkg::host_addr_t address;
	logic sdram_ready;
	logic cke;
	logic cs_n;
	logic ras_n;
	logic cas_n;
	logic we_n;
	logic [11:0] addr;
	logic [1:0] bank;
	logic [1:0] data_mask;
	wire  [15:0] data;
	logic protocol_fault;
	int refresh_seen;

	// reference memory and the words still owed by the read FIFO
	logic [31:0] ref_mem [logic [21:0]];
	logic [31:0] expect_q [$];
	logic [31:0] expected_word;
	logic [21:0] written [$];

	tb_clock_gen clock_gen (
		.sdram_clk(sdram_clk),
		.sdram_reset(sdram_reset)
	);

	sdram #(
		.refresh_interval(refresh_interval),
		.fifo_depth_log2(3)
	) sdram_inst (
		.sdram_clk(sdram_clk), .sdram_reset(sdram_reset),
		.wr_fifo_wr(wr_fifo_wr), .wr_fifo_data(wr_fifo_data), .wr_fifo_mask(wr_fifo_mask),
		.wr_fifo_full(wr_fifo_full), .rd_fifo_rd(rd_fifo_rd), .rd_fifo_data(rd_fifo_data),
		.rd_fifo_empty(rd_fifo_empty), .write_en(write_en), .read_en(read_en),
		.address(address), .sdram_ready(sdram_ready), .cke(cke), .cs_n(cs_n),
		.ras_n(ras_n), .cas_n(cas_n), .we_n(we_n), .addr(addr), .bank(bank),
		.data_mask(data_mask), .data(data)
	);

	tb_sdram_model #(
		.refresh_interval(refresh_interval)
	) memory (
		.sdram_clk(sdram_clk), .sdram_reset(sdram_reset), .cke(cke), .cs_n(cs_n),
		.ras_n(ras_n), .cas_n(cas_n), .we_n(we_n), .addr(addr), .bank(bank),
		.data_mask(data_mask), .data(data), .protocol_fault(protocol_fault),
		.refresh_seen(refresh_seen)
	);

	task automatic fail_run(string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic show_mismatch(string name, logic [31:0] exp, logic [31:0] act);
		fail_run($sformatf("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act));
	endtask

	// mask bit set keeps the old byte
	function automatic logic [31:0] merge_word(logic [31:0] old, logic [31:0] d, logic [3:0] m);
		logic [31:0] res;
		for (int i = 0; i < 4; i++) begin
			res[8*i +: 8] = m[i] ? old[8*i +: 8] : d[8*i +: 8];
		end
		return res;
	endfunction

	task automatic wait_ready(int limit);
		int n;
		n = 0;
		while (!sdram_ready && n < limit) begin
			@(posedge sdram_clk);
			#1;
			n++;
		end
		if (!sdram_ready) fail_run("timed out waiting for sdram_ready");
	endtask

	task automatic write_word(logic [21:0] a, logic [31:0] d, logic [3:0] m);
		logic [31:0] old;
		if (wr_fifo_full) show_mismatch("wr_fifo_full", 32'h0, 32'h1);
		wr_fifo_wr = 1'b1;
		wr_fifo_data = d;
		wr_fifo_mask = m;
		@(posedge sdram_clk);
		#1;
		wr_fifo_wr = 1'b0;
		wait_ready(ready_limit);
		write_en = 1'b1;
		address = a;
		@(posedge sdram_clk);
		#1;
		write_en = 1'b0;
		old = ref_mem.exists(a) ? ref_mem[a] : 32'h0;
		ref_mem[a] = merge_word(old, d, m);
	endtask

	task automatic request_read(logic [21:0] a);
		wait_ready(ready_limit);
		read_en = 1'b1;
		address = a;
		@(posedge sdram_clk);
		#1;
		read_en = 1'b0;
		expect_q.push_back(ref_mem.exists(a) ? ref_mem[a] : 32'h0);
	endtask

	task automatic pop_and_check();
		int n;
		n = 0;
		while (rd_fifo_empty && n < ready_limit) begin
			@(posedge sdram_clk);
			#1;
			n++;
		end
		if (rd_fifo_empty) fail_run("timed out waiting for a word in the read FIFO");
		expected_word = expect_q.pop_front();
		rd_fifo_rd = 1'b1;
		@(posedge sdram_clk);
		#1;
		rd_fifo_rd = 1'b0;
	endtask

	task automatic wait_refreshes(int target, int limit);
		int n;
		n = 0;
		while (refresh_seen < target && n < limit) begin
			@(posedge sdram_clk);
			#1;
			n++;
		end
		if (refresh_seen < target) fail_run("periodic AUTO_REFRESH did not show up");
	endtask

	a_model_clean: assert property (@(posedge sdram_clk) disable iff (sdram_reset)
		!protocol_fault) else fail_run("SDRAM model reported a protocol violation");
	a_reset_idle: assert property (@(posedge sdram_clk)
		$fell(sdram_reset) |-> !cke && cs_n && ras_n && cas_n && we_n)
		else fail_run("memory pins were not idle when reset was released");
	a_read_data: assert property (@(posedge sdram_clk) disable iff (sdram_reset)
		rd_fifo_rd |-> rd_fifo_data == expected_word)
		else show_mismatch("rd_fifo_data", $sampled(expected_word), $sampled(rd_fifo_data));

	initial begin
		logic [21:0] a;
		wr_fifo_wr = 1'b0;
		wr_fifo_data = 32'h0;
		wr_fifo_mask = 4'h0;
		rd_fifo_rd = 1'b0;
		write_en = 1'b0;
		read_en = 1'b0;
		address = '0;
		expected_word = 32'h0;
		void'($urandom(32'h892f_3b98));
		@(posedge sdram_clk);
		#1;
		wait_ready(init_limit);

		// full words to random addresses, then read each back
		for (int i = 0; i < write_count; i++) begin
			a = 22'($urandom());
			write_word(a, $urandom(), 4'h0);
			written.push_back(a);
		end
		foreach (written[i]) begin
			request_read(written[i]);
			pop_and_check();
		end

		// partial rewrites under random byte masks
		for (int i = 0; i < mask_count; i++) begin
			a = written[$urandom_range(written.size() - 1)];
			write_word(a, $urandom(), 4'($urandom()));
			request_read(a);
			pop_and_check();
		end

		// queue several reads before draining the FIFO
		for (int i = 0; i < burst_reads; i++) begin
			request_read(written[i]);
		end
		for (int i = 0; i < burst_reads; i++) begin
			pop_and_check();
		end
		assert (rd_fifo_empty) else show_mismatch("rd_fifo_empty", 32'h1, 32'h0);

		wait_refreshes(refresh_seen + 2, 3 * refresh_interval);
		$display("No errors");
		$finish;
	end

endmodule

//--- src.f
sdram_pkg.sv
sdram_fifo.sv
sdram_write.sv
sdram_read.sv
sdram.sv
tb_clock_gen.sv
tb_sdram_model.sv
tb_sdram.sv

//--- run.sh
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_sdram -f src.f \
	&& ./obj_dir/Vtb_sdram \
	|| exit 1
